// File: logic/spd_pkg.sv
// Shared sizes, task format and config addresses for the pruning stage.
// Sized for a 16 x 16 spike tile; QUEUE_DEPTH must stay a power of two.
package spd_pkg;

    // Tile geometry
    localparam int NUM_ROWS   = 16;
    localparam int ROW_BITS   = 4;
    localparam int SPIKE_BITS = 16;

    // A row holds at most 16 spikes, so NO needs one bit more than a row index
    localparam int NO_BITS = 5;

    // Output task FIFO
    localparam int QUEUE_DEPTH = 4;

    // Config register map, one address bit
    localparam logic CFG_ADDR_ROWS = 1'b0;
    localparam logic CFG_ADDR_MODE = 1'b1;

    // One pruned row as handed to the dispatcher
    typedef struct packed {
        logic [ROW_BITS-1:0]   row_id;
        logic [ROW_BITS-1:0]   prefix_id;
        logic [SPIKE_BITS-1:0] pattern;
    } prune_task_t;

endpackage

// File: logic/prune_if.sv
// Internal buses of the pruning stage. The tile bus has no handshake and
// relies on the tile staying unchanged while a run is busy.

// Whole tile and its per-row spike counts, all rows in parallel
interface tile_if;
    logic [spd_pkg::SPIKE_BITS-1:0] rows   [spd_pkg::NUM_ROWS];
    logic [spd_pkg::NO_BITS-1:0]    counts [spd_pkg::NUM_ROWS];

    modport source (output rows, output counts);
    modport reader (input rows, input counts);
endinterface

// One row moving between pipeline stages
interface stage_if;
    logic                           valid;
    logic [spd_pkg::ROW_BITS-1:0]   row_id;
    logic [spd_pkg::SPIKE_BITS-1:0] row_spikes;
    logic [spd_pkg::NO_BITS-1:0]    row_no;
    // Candidate prefix rows, one bit per tile row
    logic [spd_pkg::NUM_ROWS-1:0]   mask;

    modport source (output valid, output row_id, output row_spikes, output row_no, output mask);
    modport sink (input valid, input row_id, input row_spikes, input row_no, input mask);
endinterface

// File: logic/spike_tile_store.sv
// Spike row registers with one write port. Writes while busy are dropped,
// so the tile is frozen for the whole run.
module spike_tile_store (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [spd_pkg::ROW_BITS-1:0]   wr_addr,
    input  logic [spd_pkg::SPIKE_BITS-1:0] wr_spikes,
    input  logic                           busy,
    tile_if.source                         tile
);

    logic [spd_pkg::SPIKE_BITS-1:0] rows_q   [spd_pkg::NUM_ROWS];
    logic [spd_pkg::NO_BITS-1:0]    counts_q [spd_pkg::NUM_ROWS];
    logic                           wr_accept;
    logic [spd_pkg::NO_BITS-1:0]    wr_no;

    assign wr_accept = wr_en && !busy;

    // NO of the incoming row, stored next to it on the same edge
    assign wr_no = (spd_pkg::NO_BITS)'($countones(wr_spikes));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < spd_pkg::NUM_ROWS; i++) begin
                rows_q[i]   <= '0;
                counts_q[i] <= '0;
            end
        end else if (wr_accept) begin
            rows_q[wr_addr]   <= wr_spikes;
            counts_q[wr_addr] <= wr_no;
        end
    end

    assign tile.rows   = rows_q;
    assign tile.counts = counts_q;

endmodule

// File: logic/prune_config.sv
// Run settings. A row count of 0, or above the tile size, selects all rows.
// Writes are ignored while busy.
module prune_config (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_wr,
    input  logic                       cfg_addr,
    input  logic [spd_pkg::ROW_BITS:0] cfg_data,
    input  logic                       busy,
    output logic [spd_pkg::ROW_BITS:0] row_count,
    output logic                       exact_en
);

    logic                       cfg_accept;
    logic                       rows_full;
    logic [spd_pkg::ROW_BITS:0] rows_value;

    assign cfg_accept = cfg_wr && !busy;

    // Keep row_count in 1..NUM_ROWS
    assign rows_full  = (cfg_data == '0) ||
                        (cfg_data > (spd_pkg::ROW_BITS + 1)'(spd_pkg::NUM_ROWS));
    assign rows_value = rows_full ? (spd_pkg::ROW_BITS + 1)'(spd_pkg::NUM_ROWS) : cfg_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_count <= (spd_pkg::ROW_BITS + 1)'(spd_pkg::NUM_ROWS);
            exact_en  <= 1'b0;
        end else if (cfg_accept) begin
            if (cfg_addr == spd_pkg::CFG_ADDR_ROWS) begin
                row_count <= rows_value;
            end
            if (cfg_addr == spd_pkg::CFG_ADDR_MODE) begin
                exact_en <= cfg_data[0];
            end
        end
    end

endmodule

// File: logic/subset_detector.sv
// Candidate prefix search for the issued row, registered one cycle after issue.
// Only rows below row_count are tested; the tile must not change during a run.
module subset_detector (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       exact_en,
    input  logic [spd_pkg::ROW_BITS:0] row_count,
    tile_if.reader                     tile,
    stage_if.sink                      issue,
    stage_if.source                    cand
);

    logic [spd_pkg::SPIKE_BITS-1:0] cur_spikes;
    logic [spd_pkg::NO_BITS-1:0]    cur_no;
    logic [spd_pkg::NUM_ROWS-1:0]   in_range;
    logic [spd_pkg::NUM_ROWS-1:0]   partial_hit;
    logic [spd_pkg::NUM_ROWS-1:0]   exact_hit;
    logic [spd_pkg::NUM_ROWS-1:0]   mask_next;

    assign cur_spikes = tile.rows[issue.row_id];
    assign cur_no     = tile.counts[issue.row_id];

    // One comparator set per tile row, all evaluated in the same cycle
    for (genvar g = 0; g < spd_pkg::NUM_ROWS; g++) begin : g_cand
        assign in_range[g] = (spd_pkg::ROW_BITS + 1)'(g) < row_count;

        // Proper subset: no spike outside the current row and fewer spikes
        assign partial_hit[g] = ((tile.rows[g] & ~cur_spikes) == '0) &&
                                (tile.counts[g] < cur_no);

        // Exact copy only counts when the copy sits earlier in the tile
        assign exact_hit[g] = exact_en &&
                              (tile.rows[g] == cur_spikes) &&
                              ((spd_pkg::ROW_BITS)'(g) < issue.row_id);
    end

    // The row itself never matches (equal NO, not a lower index)
    assign mask_next = (partial_hit | exact_hit) & in_range;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand.valid <= 1'b0;
        end else begin
            cand.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            cand.row_id     <= issue.row_id;
            cand.row_spikes <= cur_spikes;
            cand.row_no     <= cur_no;
            cand.mask       <= mask_next;
        end
    end

endmodule

// File: logic/prefix_pruner.sv
// Picks the prefix with the largest NO among the candidates, lowest index on ties,
// and registers the task. No candidate means self-prefix with a zero pattern.
module prefix_pruner (
    input  logic                 clk,
    input  logic                 rst_n,
    tile_if.reader               tile,
    stage_if.sink                cand,
    output logic                 task_valid,
    output spd_pkg::prune_task_t task_data
);

    logic                           found;
    logic [spd_pkg::ROW_BITS-1:0]   best_idx;
    logic [spd_pkg::NO_BITS-1:0]    best_no;
    logic [spd_pkg::SPIKE_BITS-1:0] prefix_spikes;
    logic [spd_pkg::SPIKE_BITS-1:0] pattern_next;

    // Priority reduction in index order, so only a strictly larger NO
    // can displace an earlier winner
    always_comb begin
        found    = 1'b0;
        best_idx = cand.row_id;
        best_no  = '0;
        for (int g = 0; g < spd_pkg::NUM_ROWS; g++) begin
            if (cand.mask[g] && (!found || tile.counts[g] > best_no)) begin
                found    = 1'b1;
                best_idx = (spd_pkg::ROW_BITS)'(g);
                best_no  = tile.counts[g];
            end
        end
    end

    // Falls back to the row's own spikes when nothing matched
    assign prefix_spikes = found ? tile.rows[best_idx] : cand.row_spikes;
    assign pattern_next  = cand.row_spikes ^ prefix_spikes;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            task_valid <= 1'b0;
        end else begin
            task_valid <= cand.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cand.valid) begin
            task_data.row_id    <= cand.row_id;
            task_data.prefix_id <= best_idx;
            task_data.pattern   <= pattern_next;
        end
    end

endmodule

// File: logic/task_queue.sv
// Task FIFO with a four-phase req/ack head. Push into a full queue is not
// guarded; the sequencer's credit check keeps that from happening.
module task_queue (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  push,
    input  spd_pkg::prune_task_t                  push_data,
    output logic [$clog2(spd_pkg::QUEUE_DEPTH):0] free_count,
    output logic                                  empty,
    output logic                                  task_req,
    input  logic                                  task_ack,
    output spd_pkg::prune_task_t                  head_data
);

    spd_pkg::prune_task_t                    mem [spd_pkg::QUEUE_DEPTH];
    logic [$clog2(spd_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(spd_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(spd_pkg::QUEUE_DEPTH):0]   count;
    logic                                    ack_seen;
    logic                                    pop;

    assign empty      = (count == '0);
    assign free_count = ($clog2(spd_pkg::QUEUE_DEPTH) + 1)'(spd_pkg::QUEUE_DEPTH) - count;
    assign head_data  = mem[rd_ptr];

    // Head leaves only once ack has dropped again
    assign pop = ack_seen && !task_ack;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            task_req <= 1'b0;
            ack_seen <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Four-phase sequence on the head entry
            if (!task_req && !ack_seen && !empty && !task_ack) begin
                task_req <= 1'b1;
            end else if (task_req && task_ack) begin
                task_req <= 1'b0;
                ack_seen <= 1'b1;
            end else if (pop) begin
                ack_seen <= 1'b0;
            end
        end
    end

endmodule

// File: logic/prune_sequencer.sv
// Walks rows 0..row_count-1, one per cycle at most, gated by queue credit.
// start_ack rises once the queue has drained and stays up until start_req drops.
module prune_sequencer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start_req,
    output logic                                  start_ack,
    input  logic [spd_pkg::ROW_BITS:0]            row_count,
    input  logic [$clog2(spd_pkg::QUEUE_DEPTH):0] free_count,
    input  logic                                  empty,
    input  logic                                  task_valid,
    stage_if.source                               issue,
    output logic                                  busy
);

    logic                                  running;
    logic [spd_pkg::ROW_BITS:0]            next_row;
    // Rows issued but not yet written into the queue
    logic [$clog2(spd_pkg::QUEUE_DEPTH):0] in_flight;
    logic                                  rows_left;
    logic                                  credit_ok;
    logic                                  issue_fire;
    logic                                  drained;

    assign rows_left  = next_row < row_count;
    assign credit_ok  = free_count > in_flight;
    assign issue_fire = running && rows_left && credit_ok;
    assign drained    = !rows_left && (in_flight == '0) && empty;

    assign issue.valid  = issue_fire;
    assign issue.row_id = next_row[spd_pkg::ROW_BITS-1:0];

    // The detector fetches spikes and NO itself
    assign issue.row_spikes = '0;
    assign issue.row_no     = '0;
    assign issue.mask       = '0;

    assign busy = running;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            start_ack <= 1'b0;
            next_row  <= '0;
            in_flight <= '0;
        end else begin
            if (!running && !start_ack && start_req) begin
                running  <= 1'b1;
                next_row <= '0;
            end else if (running && drained) begin
                running   <= 1'b0;
                start_ack <= 1'b1;
            end else if (start_ack && !start_req) begin
                start_ack <= 1'b0;
            end

            if (issue_fire) begin
                next_row <= next_row + 1'b1;
            end

            // A push retires one in-flight row
            case ({issue_fire, task_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

endmodule

// File: logic/prosparsity_top.sv
// Prefix-pruning stage for one 16 x 16 spike tile.
// Load and config writes are dropped while busy is high.
module prosparsity_top (
    input  logic                           clk,
    input  logic                           rst_n,
    // Tile load
    input  logic                           wr_en,
    input  logic [spd_pkg::ROW_BITS-1:0]   wr_addr,
    input  logic [spd_pkg::SPIKE_BITS-1:0] wr_spikes,
    // Config
    input  logic                           cfg_wr,
    input  logic                           cfg_addr,
    input  logic [spd_pkg::ROW_BITS:0]     cfg_data,
    // Run control
    input  logic                           start_req,
    output logic                           start_ack,
    output logic                           busy,
    // Task output, four-phase
    output logic                           task_req,
    input  logic                           task_ack,
    output logic [spd_pkg::ROW_BITS-1:0]   task_row,
    output logic [spd_pkg::ROW_BITS-1:0]   task_prefix,
    output logic [spd_pkg::SPIKE_BITS-1:0] task_pattern
);

    logic [spd_pkg::ROW_BITS:0]            row_count;
    logic                                  exact_en;
    logic [$clog2(spd_pkg::QUEUE_DEPTH):0] free_count;
    logic                                  empty;
    logic                                  task_valid;
    spd_pkg::prune_task_t                  task_data;
    spd_pkg::prune_task_t                  head_data;

    tile_if  tile_bus ();
    stage_if issue_bus ();
    stage_if cand_bus ();

    spike_tile_store u_store (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr),
        .wr_spikes(wr_spikes), .busy(busy), .tile(tile_bus)
    );

    prune_config u_config (
        .clk(clk), .rst_n(rst_n), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .busy(busy), .row_count(row_count), .exact_en(exact_en)
    );

    prune_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start_req(start_req), .start_ack(start_ack),
        .row_count(row_count), .free_count(free_count), .empty(empty),
        .task_valid(task_valid), .issue(issue_bus), .busy(busy)
    );

    subset_detector u_detect (
        .clk(clk), .rst_n(rst_n), .exact_en(exact_en), .row_count(row_count),
        .tile(tile_bus), .issue(issue_bus), .cand(cand_bus)
    );

    prefix_pruner u_prune (
        .clk(clk), .rst_n(rst_n), .tile(tile_bus), .cand(cand_bus),
        .task_valid(task_valid), .task_data(task_data)
    );

    // Pruner output goes into the queue on the edge it is registered
    task_queue u_queue (
        .clk(clk), .rst_n(rst_n), .push(task_valid), .push_data(task_data),
        .free_count(free_count), .empty(empty), .task_req(task_req),
        .task_ack(task_ack), .head_data(head_data)
    );

    assign task_row     = head_data.row_id;
    assign task_prefix  = head_data.prefix_id;
    assign task_pattern = head_data.pattern;

endmodule

// File: test/tb_prosparsity.sv
// Vector-driven testbench for the pruning stage. Expected tasks come precomputed in the
// vectors file; load and config words placed right after a start are applied mid-run.
module tb_prosparsity;

    localparam int HALF_PERIOD = 20;
    localparam int VEC_WORDS   = 128;
    // Per row at most two 7-cycle ack delays plus about 6 cycles of handshake
    localparam int RUN_LIMIT   = spd_pkg::NUM_ROWS * 25;

    localparam logic [3:0] OP_LOAD   = 4'h1;
    localparam logic [3:0] OP_CONFIG = 4'h2;
    localparam logic [3:0] OP_START  = 4'h3;
    localparam logic [3:0] OP_EXPECT = 4'h4;
    localparam logic [3:0] OP_END    = 4'hF;

    logic                           clk;
    logic                           rst_n;
    logic                           wr_en;
    logic [spd_pkg::ROW_BITS-1:0]   wr_addr;
    logic [spd_pkg::SPIKE_BITS-1:0] wr_spikes;
    logic                           cfg_wr;
    logic                           cfg_addr;
    logic [spd_pkg::ROW_BITS:0]     cfg_data;
    logic                           start_req;
    logic                           start_ack;
    logic                           busy;
    logic                           task_req;
    logic                           task_ack;
    logic [spd_pkg::ROW_BITS-1:0]   task_row;
    logic [spd_pkg::ROW_BITS-1:0]   task_prefix;
    logic [spd_pkg::SPIKE_BITS-1:0] task_pattern;

    logic [31:0] vectors [VEC_WORDS];
    logic [31:0] exp_q [$];
    logic [15:0] lfsr;
    int          errors;
    int          tasks_seen;
    int          run_cycles;

    prosparsity_top u_dut (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_spikes(wr_spikes),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .start_req(start_req), .start_ack(start_ack), .busy(busy),
        .task_req(task_req), .task_ack(task_ack), .task_row(task_row),
        .task_prefix(task_prefix), .task_pattern(task_pattern)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end else begin
            return state >> 1;
        end
    endfunction

    // Three LFSR bits give a delay of 0 to 7 cycles
    task automatic pick_delay(output int delay);
        delay = 0;
        for (int b = 0; b < 3; b++) begin
            delay = (delay << 1) | int'(lfsr[0]);
            lfsr  = next_lfsr(lfsr);
        end
    endtask

    task automatic write_row(input logic [31:0] word);
        wr_en     = 1'b1;
        wr_addr   = word[27:24];
        wr_spikes = word[15:0];
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic write_config(input logic [31:0] word);
        cfg_wr   = 1'b1;
        cfg_addr = word[24];
        cfg_data = word[4:0];
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic begin_run;
        run_cycles = 0;
        start_req  = 1'b1;
        @(negedge clk);
        while (busy !== 1'b1) @(negedge clk);
    endtask

    task automatic finish_run;
        while (start_ack !== 1'b1) @(negedge clk);
        if (task_ack !== 1'b0 || task_req !== 1'b0) begin
            errors++;
            $display("start_ack rose while a task handshake was still open");
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Run ended with %0d expected tasks not received", exp_q.size());
            exp_q.delete();
        end
        start_req = 1'b0;
        while (start_ack !== 1'b0) @(negedge clk);
        run_cycles = 0;
    endtask

    task automatic check_task;
        logic [31:0] want;
        tasks_seen++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Extra task for row %0d arrived with no task expected", task_row);
        end else begin
            want = exp_q.pop_front();
            if (task_row !== want[27:24]) begin
                errors++;
                $display("[FAIL] task_row: got %h expected %h", task_row, want[27:24]);
            end
            if (task_prefix !== want[23:20]) begin
                errors++;
                $display("[FAIL] task_prefix: got %h expected %h", task_prefix, want[23:20]);
            end
            if (task_pattern !== want[15:0]) begin
                errors++;
                $display("[FAIL] task_pattern: got %h expected %h", task_pattern, want[15:0]);
            end
        end
    endtask

    // Four-phase responder with random delay before each ack edge
    initial begin : ack_responder
        int delay;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && task_req === 1'b1) begin
                check_task();
                pick_delay(delay);
                repeat (delay) @(negedge clk);
                task_ack = 1'b1;
                do @(negedge clk); while (task_req !== 1'b0);
                pick_delay(delay);
                repeat (delay) @(negedge clk);
                task_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        while (run_cycles < RUN_LIMIT) begin
            @(posedge clk);
            run_cycles++;
        end
        $display("Timeout after %0d cycles without the run completing", RUN_LIMIT);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] word;
        int          idx;
        logic        run_open;
        logic        done;
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_spikes  = '0;
        cfg_wr     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_data   = '0;
        start_req  = 1'b0;
        task_ack   = 1'b0;
        lfsr       = 16'd37;
        errors     = 0;
        tasks_seen = 0;
        run_cycles = 0;
        $readmemh("test/prune_vectors.hex", vectors);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (start_ack !== 1'b0) begin
            errors++;
            $display("[FAIL] start_ack after reset: got %h expected 0", start_ack);
        end
        if (task_req !== 1'b0) begin
            errors++;
            $display("[FAIL] task_req after reset: got %h expected 0", task_req);
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("[FAIL] busy after reset: got %h expected 0", busy);
        end

        idx      = 0;
        run_open = 1'b0;
        done     = 1'b0;
        while (!done) begin
            if (idx >= VEC_WORDS) begin
                errors++;
                $display("Vectors file ended without an end word");
                done = 1'b1;
            end else begin
                word = vectors[idx];
                idx++;
                // Anything but a load or config word closes the open run
                if (run_open && word[31:28] != OP_LOAD && word[31:28] != OP_CONFIG) begin
                    finish_run();
                    run_open = 1'b0;
                end
                case (word[31:28])
                    OP_LOAD:   write_row(word);
                    OP_CONFIG: write_config(word);
                    OP_START: begin
                        begin_run();
                        run_open = 1'b1;
                    end
                    OP_EXPECT: exp_q.push_back(word);
                    OP_END:    done = 1'b1;
                    default: begin
                        errors++;
                        $display("Unknown opcode %h in vector word %0d", word[31:28], idx - 1);
                        done = 1'b1;
                    end
                endcase
            end
        end

        $display("Tasks checked: %0d, errors: %0d", tasks_seen, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: test/prune_vectors.hex
// Opcode [31:28]. 1 load: row [27:24], spikes [15:0]. 2 config: addr [24], data [4:0].
// 3 start. 4 expected task: row [27:24], prefix [23:20], pattern [15:0]. F end.
// Load/config words right after a start are written while that run is busy
// Run A: empty tile after reset, every row is its own prefix
40000000 41100000 42200000 43300000 44400000 45500000 46600000 47700000
48800000 49900000 4AA00000 4BB00000 4CC00000 4DD00000 4EE00000 4FF00000
30000000
// Run B: nested subsets, exact-match off
40900001 41000002 42100004 43200008 44000002 45000004 46900100 47600002
48300100 49900000 4A600E00 4BE00004 4C200008 4D90F000 4E900002 4F80FEF0
10000001 11000003 12000007 1300000F 14000003 15000005 16000100 17000102
1800010F 19000000 1A000F00 1B000006 1C00000F 1D00F000 1E000002 1F00FFFF
30000000
// Run C: exact-match on, duplicates 4 and 12 take rows 1 and 3
40900001 41000002 42100004 43200008 44100000 45000004 46900100 47600002
48300100 49900000 4A600E00 4BE00004 4C300000 4D90F000 4E900002 4F80FEF0
21000001
30000000
// Dropped while busy
1F000000 20000006
// Run D: six rows, row 9 out of range so row 0 is its own prefix
40000000 41000002 42100004 43200008 44100000 45000004
20000006
30000000
F0000000

// File: files.f
logic/spd_pkg.sv
logic/prune_if.sv
logic/spike_tile_store.sv
logic/prune_config.sv
logic/subset_detector.sv
logic/prefix_pruner.sv
logic/task_queue.sv
logic/prune_sequencer.sv
logic/prosparsity_top.sv
test/tb_prosparsity.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_prosparsity -Mdir "$BUILD"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/Vtb_prosparsity" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\* FAIL \*\*" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
